// File: audio_pkg.sv
`default_nettype none

package audio_pkg;

    ////////////////////////////////////////////////////////////
    // ADC sample format
    ////////////////////////////////////////////////////////////

    localparam int sample_bits = 12;    // Mic ADC resolution
    localparam int level_bits  = 4;     // Volume level 0..15

    // Short window so simulation finishes quickly
    localparam int window_len = 8;

    ////////////////////////////////////////////////////////////
    // Serial frame timing, all in clk cycles
    ////////////////////////////////////////////////////////////

    localparam int frame_cycles = 40;   // Frame start to frame start
    localparam int frame_bits   = 16;   // 4 leading zeros + 12 data bits

    // Two clk cycles per serial clock period
    localparam int cs_low_cycles = 2 * frame_bits;

    // Volume level handed from the detector to the displays
    typedef struct packed {
        logic [level_bits-1:0] value;   // Held between windows
        logic                  valid;   // One cycle per finished window
    } level_t;

endpackage

`default_nettype wire

// File: display_pkg.sv
`default_nettype none

package display_pkg;

    ////////////////////////////////////////////////////////////
    // OLED screen
    ////////////////////////////////////////////////////////////

    localparam int scr_width        = 96;
    localparam int scr_height       = 64;
    localparam int pixel_index_bits = 13;   // Row-major, y * 96 + x
    localparam int colour_bits      = 16;   // RGB565

    localparam logic [colour_bits-1:0] colour_black = 16'h0000;
    localparam logic [colour_bits-1:0] colour_white = 16'hFFFF;
    localparam logic [colour_bits-1:0] colour_green = 16'h07E0;   // Full G field only

    localparam int bar_step = 4;    // Rows per level step

    // Screen selection from the top level
    typedef enum logic [1:0] {
        mode_menu   = 2'd0,
        mode_volume = 2'd1
    } screen_mode_e;    // 2 and 3 unused, shown black

    ////////////////////////////////////////////////////////////
    // LEDs and seven segments
    ////////////////////////////////////////////////////////////

    localparam int led_bits    = 16;
    localparam int scan_cycles = 64;    // Time each digit stays lit

    // Active low, bit 7 = dp, bits 6..0 = g..a
    localparam logic [9:0][7:0] seg_digits = {
        8'h90, 8'h80, 8'hF8, 8'h82, 8'h92,  // 9 8 7 6 5
        8'h99, 8'hB0, 8'hA4, 8'hF9, 8'hC0   // 4 3 2 1 0
    };

    typedef struct packed {
        logic [3:0] an;     // Digit enables, active low
        logic [7:0] seg;    // Segments, active low
    } seg_drive_t;

endpackage

`default_nettype wire

// File: mic_capture.sv
`default_nettype none

module mic_capture (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             adc_miso,
    output logic                             adc_cs,
    output logic                             adc_sclk,
    output logic [audio_pkg::sample_bits-1:0] sample,
    output logic                             sample_valid
);

    localparam int cnt_bits = $clog2(audio_pkg::frame_cycles);

    localparam logic [cnt_bits-1:0] last_cnt = cnt_bits'(audio_pkg::frame_cycles - 1);
    localparam logic [cnt_bits-1:0] cs_end   = cnt_bits'(audio_pkg::cs_low_cycles);

    logic [cnt_bits-1:0]              frame_cnt;
    logic [cnt_bits-1:0]              cnt_next;
    logic [audio_pkg::frame_bits-1:0] shift_q;     // Whole frame, zeros on top

    assign cnt_next = (frame_cnt == last_cnt) ? '0 : frame_cnt + 1'b1;

    ////////////////////////////////////////////////////////////
    // Frame timing
    ////////////////////////////////////////////////////////////

    // cs and sclk registered straight from the next count,
    // so they always match the decode of frame_cnt
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame_cnt    <= last_cnt;   // Idle tail, first frame next cycle
            adc_cs       <= 1'b1;
            adc_sclk     <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            frame_cnt    <= cnt_next;
            adc_cs       <= (cnt_next >= cs_end);
            adc_sclk     <= (cnt_next < cs_end) & cnt_next[0];  // Odd counts high
            sample_valid <= (frame_cnt == cs_end);              // cycle after cs rises
        end
    end

    ////////////////////////////////////////////////////////////
    // Serial shift and sample load
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        // sclk low inside frame, so this edge is a rising sclk edge
        if (!adc_cs && !adc_sclk) begin
            shift_q <= {shift_q[audio_pkg::frame_bits-2:0], adc_miso};  // MSB first
        end
        // Last shift was two counts earlier
        if (frame_cnt == cs_end) begin
            sample <= shift_q[audio_pkg::sample_bits-1:0];  // Drop leading zeros
        end
    end

endmodule

`default_nettype wire

// File: peak_detector.sv
`default_nettype none

module peak_detector (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [audio_pkg::sample_bits-1:0] sample,
    input  logic                              sample_valid,
    output audio_pkg::level_t                 level
);

    localparam int cnt_bits  = $clog2(audio_pkg::window_len);
    localparam int lvl_shift = audio_pkg::sample_bits - audio_pkg::level_bits;

    localparam logic [cnt_bits-1:0] last_cnt = cnt_bits'(audio_pkg::window_len - 1);

    logic [audio_pkg::sample_bits-1:0] max_q;      // Running max of this window
    logic [audio_pkg::sample_bits-1:0] max_next;
    logic [cnt_bits-1:0]               cnt_q;      // Samples seen so far

    // Max including the sample arriving now
    assign max_next = (sample > max_q) ? sample : max_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            max_q       <= '0;
            cnt_q       <= '0;
            level.value <= '0;
            level.valid <= 1'b0;
        end else begin
            level.valid <= 1'b0;    // Strobe by default
            if (sample_valid) begin
                if (cnt_q == last_cnt) begin
                    // Top bits of the peak are the level
                    level.value <= audio_pkg::level_bits'(max_next >> lvl_shift);
                    level.valid <= 1'b1;
                    max_q       <= '0;  // Next window starts clean
                    cnt_q       <= '0;
                end else begin
                    max_q <= max_next;
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: level_display.sv
`default_nettype none

module level_display (
    input  logic                                clk,
    input  logic                                rst_n,
    input  audio_pkg::level_t                   level,
    output logic [display_pkg::led_bits-1:0]    led,
    output display_pkg::seg_drive_t             seg_out
);

    localparam int scan_bits = $clog2(display_pkg::scan_cycles);

    localparam logic [scan_bits-1:0] scan_last = scan_bits'(display_pkg::scan_cycles - 1);

    logic [display_pkg::led_bits-1:0] led_next;
    logic [3:0]                       units_next, tens_next;
    logic [3:0]                       units_q, tens_q;
    logic [3:0]                       cur_digit;   // Digit value under the scan
    logic [scan_bits-1:0]             scan_cnt;
    logic                             digit_sel;   // 0 units, 1 tens
    logic                             scan_on;     // Set at first scan step

    // Bar graph, lowest bits first
    always_comb begin
        for (int i = 0; i < display_pkg::led_bits; i++) begin
            led_next[i] = (i < int'(level.value));
        end
    end

    // Level is at most 15, tens is 0 or 1
    assign tens_next  = (level.value >= 4'd10) ? 4'd1 : 4'd0;
    assign units_next = (level.value >= 4'd10) ? level.value - 4'd10 : level.value;
    assign cur_digit  = digit_sel ? tens_q : units_q;

    ////////////////////////////////////////////////////////////
    // Level capture
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            led     <= '0;
            units_q <= '0;
            tens_q  <= '0;
        end else if (level.valid) begin
            led     <= led_next;
            units_q <= units_next;
            tens_q  <= tens_next;   // Leading zero still shown
        end
    end

    ////////////////////////////////////////////////////////////
    // Digit scan
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan_cnt    <= '0;
            digit_sel   <= 1'b0;
            scan_on     <= 1'b0;
            seg_out.an  <= 4'b1111;     // All digits dark
            seg_out.seg <= 8'hFF;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
            if (scan_cnt == scan_last) begin
                scan_cnt  <= '0;
                digit_sel <= ~digit_sel;
                scan_on   <= 1'b1;
            end
            if (scan_on) begin
                seg_out.an  <= digit_sel ? 4'b1101 : 4'b1110;  // Upper two always off
                seg_out.seg <= display_pkg::seg_digits[cur_digit];
            end
        end
    end

endmodule

`default_nettype wire

// File: pixel_renderer.sv
`default_nettype none

module pixel_renderer (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  display_pkg::screen_mode_e                mode,
    input  logic [display_pkg::pixel_index_bits-1:0] pixel_index,
    input  audio_pkg::level_t                        level,
    output logic [display_pkg::colour_bits-1:0]      pixel_data
);

    localparam logic [6:0] last_col = 7'(display_pkg::scr_width - 1);
    localparam logic [6:0] last_row = 7'(display_pkg::scr_height - 1);
    localparam logic [6:0] num_rows = 7'(display_pkg::scr_height);

    logic [6:0]                         col, row;
    logic [7:0]                         bar_top;     // First green row
    logic                               on_border;
    logic                               in_screen;
    logic [audio_pkg::level_bits-1:0]   level_q;     // Latched level
    logic [display_pkg::colour_bits-1:0] colour_next;

    ////////////////////////////////////////////////////////////
    // Index to coordinates
    ////////////////////////////////////////////////////////////

    assign row = 7'(pixel_index / display_pkg::scr_width);
    assign col = 7'(pixel_index % display_pkg::scr_width);

    assign in_screen = (row < num_rows);    // Indices past the last row
    assign on_border = (row == '0) || (row == last_row) ||
                       (col == '0) || (col == last_col);

    // 64 at level 0, so no row is green
    assign bar_top = 8'(display_pkg::scr_height - display_pkg::bar_step * int'(level_q));

    // Colour by screen
    always_comb begin
        colour_next = display_pkg::colour_black;
        case (mode)
            display_pkg::mode_menu: begin
                if (in_screen && on_border) begin
                    colour_next = display_pkg::colour_white;   // Frame
                end
            end
            display_pkg::mode_volume: begin
                if (in_screen && ({1'b0, row} >= bar_top)) begin
                    colour_next = display_pkg::colour_green;   // Bar grows up
                end
            end
            default: colour_next = display_pkg::colour_black;  // Codes 2 and 3
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pixel_data <= display_pkg::colour_black;
            level_q    <= '0;
        end else begin
            pixel_data <= colour_next;  // One cycle after index
            if (level.valid) begin
                level_q <= level.value;
            end
        end
    end

endmodule

`default_nettype wire

// File: audio_meter_top.sv
`default_nettype none

module audio_meter_top (
    input  logic                                     clk,
    input  logic                                     rst_n,
    // Mic ADC serial link
    input  logic                                     adc_miso,
    output logic                                     adc_cs,
    output logic                                     adc_sclk,
    // OLED pixel lookup
    input  display_pkg::screen_mode_e                mode,
    input  logic [display_pkg::pixel_index_bits-1:0] pixel_index,
    output logic [display_pkg::colour_bits-1:0]      pixel_data,
    // Board LEDs and digits
    output logic [display_pkg::led_bits-1:0]         led,
    output display_pkg::seg_drive_t                  seg_out
);

    logic [audio_pkg::sample_bits-1:0] sample;
    logic                              sample_valid;
    audio_pkg::level_t                 level;   // Shared by both displays

    mic_capture u_mic_capture (
        .clk          (clk),
        .rst_n        (rst_n),
        .adc_miso     (adc_miso),
        .adc_cs       (adc_cs),
        .adc_sclk     (adc_sclk),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    peak_detector u_peak_detector (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample       (sample),
        .sample_valid (sample_valid),
        .level        (level)
    );

    level_display u_level_display (
        .clk     (clk),
        .rst_n   (rst_n),
        .level   (level),
        .led     (led),
        .seg_out (seg_out)
    );

    pixel_renderer u_pixel_renderer (
        .clk         (clk),
        .rst_n       (rst_n),
        .mode        (mode),
        .pixel_index (pixel_index),
        .level       (level),
        .pixel_data  (pixel_data)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    localparam int half_period = 50;    // Full period 100

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

endmodule

`default_nettype wire

// File: tb_audio_meter.sv
`default_nettype none

module tb_audio_meter;

    localparam int max_tests   = 16;
    localparam int scan_window = 2 * display_pkg::scan_cycles + 4;  // Both digits seen

    logic                      clk, rst_n, adc_miso, adc_cs, adc_sclk;
    display_pkg::screen_mode_e mode;
    logic [12:0]               pixel_index;
    logic [15:0]               pixel_data, led;
    display_pkg::seg_drive_t   seg_out;

    logic [11:0] sample_q [$];          // Samples still to be sent by the ADC model
    logic [15:0] frame_word;            // Current serial frame, zeros on top
    int          bit_idx;
    logic        prev_cs  = 1'b1;
    int          cs_rises = 0;          // One per finished frame
    int          cycles   = 0;
    int          cycle_limit, seed, num_tests, errors;

    // Per-window expectations
    logic [3:0]  exp_level [max_tests];
    logic [1:0]  probe_mode [max_tests];
    logic [12:0] probe_idx [max_tests][2];
    logic [15:0] probe_col [max_tests][2];

    tb_clock_gen u_clock_gen (.clk(clk));

    audio_meter_top u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .adc_miso    (adc_miso),
        .adc_cs      (adc_cs),
        .adc_sclk    (adc_sclk),
        .mode        (mode),
        .pixel_index (pixel_index),
        .pixel_data  (pixel_data),
        .led         (led),
        .seg_out     (seg_out)
    );

    ////////////////////////////////////////////////////////////
    // ADC model and run limit
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (prev_cs && !adc_cs) begin
            frame_word = (sample_q.size() > 0) ? {4'h0, sample_q.pop_front()} : 16'h0;
            bit_idx    = 15;
        end
        if (!adc_cs && !adc_sclk && bit_idx >= 0) begin
            adc_miso = frame_word[bit_idx];   // MSB first, sclk low
            bit_idx  = bit_idx - 1;
        end
        if (!prev_cs && adc_cs) begin
            cs_rises <= cs_rises + 1;
        end
        prev_cs <= adc_cs;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, windows did not finish", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Expected values and reporting
    ////////////////////////////////////////////////////////////

    // Active-low segments, dp off
    function automatic logic [7:0] digit_pattern(input int d);
        case (d)
            0:       return 8'hC0;
            1:       return 8'hF9;
            2:       return 8'hA4;
            3:       return 8'hB0;
            4:       return 8'h99;
            5:       return 8'h92;
            6:       return 8'h82;
            7:       return 8'hF8;
            8:       return 8'h80;
            9:       return 8'h90;
            default: return 8'hFF;
        endcase
    endfunction

    function automatic logic [15:0] bar_pattern(input int lvl);
        logic [16:0] ones;
        ones = (17'h1 << lvl) - 17'h1;  // lvl lowest LEDs lit
        return ones[15:0];
    endfunction

    task automatic report_mismatch(input string name, input logic [15:0] exp_v,
                                   input logic [15:0] act_v);
        $display("Error at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
        errors++;
    endtask

    // Reads columns rnd s0..s7 level mode idx_a colour_a idx_b colour_b
    task automatic read_tests();
        int    fd, n, peak;
        int    f [15];
        string line;
        fd = $fopen("audio_meter_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open audio_meter_tests.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && num_tests < max_tests) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1],
                        f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
                        f[12], f[13], f[14]);
            if (n != 15) begin
                $display("Malformed line in audio_meter_tests.txt: %s", line);
                errors++;
                continue;
            end
            peak = 0;
            for (int i = 1; i <= 8; i++) begin
                if (f[0] != 0) f[i] = $random(seed) & f[i];  // Column is a mask
                if (f[i] > peak) peak = f[i];
                sample_q.push_back(12'(f[i]));
            end
            exp_level[num_tests]    = (f[0] != 0) ? 4'(peak >> 8) : 4'(f[9]);
            probe_mode[num_tests]   = 2'(f[10]);
            probe_idx[num_tests][0] = 13'(f[11]);
            probe_col[num_tests][0] = 16'(f[12]);
            probe_idx[num_tests][1] = 13'(f[13]);
            probe_col[num_tests][1] = 16'(f[14]);
            num_tests++;
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////
    // One window: LEDs, digit scan, pixel probes
    ////////////////////////////////////////////////////////////

    task automatic check_window(input int t);
        int          err_start;
        bit          seen_units, seen_tens;
        logic [7:0]  exp_units, exp_tens;
        err_start  = errors;
        exp_units  = digit_pattern(int'(exp_level[t]) % 10);
        exp_tens   = digit_pattern(int'(exp_level[t]) / 10);
        seen_units = 0;
        seen_tens  = 0;
        while (cs_rises < 8 * (t + 1)) @(negedge clk);   // 8th frame of this window
        repeat (4) @(negedge clk);
        if (led !== bar_pattern(int'(exp_level[t]))) begin
            report_mismatch("led", bar_pattern(int'(exp_level[t])), led);
        end
        for (int i = 0; i < scan_window; i++) begin
            @(negedge clk);
            if (seg_out.an == 4'b1110) begin
                seen_units = 1;
                if (seg_out.seg !== exp_units) begin
                    report_mismatch("seg units", exp_units, seg_out.seg);
                end
            end else if (seg_out.an == 4'b1101) begin
                seen_tens = 1;
                if (seg_out.seg !== exp_tens) begin
                    report_mismatch("seg tens", exp_tens, seg_out.seg);
                end
            end else begin
                $display("Error at %0t: seg_out.an is %b, not one of 1110 and 1101",
                         $time, seg_out.an);
                errors++;
            end
        end
        if (!seen_units || !seen_tens) begin
            $display("Window %0d: digit scan never enabled both digits", t);
            errors++;
        end
        for (int p = 0; p < 2; p++) begin
            mode        = display_pkg::screen_mode_e'(probe_mode[t]);
            pixel_index = probe_idx[t][p];
            @(negedge clk);             // Registered one cycle later
            if (pixel_data !== probe_col[t][p]) begin
                report_mismatch("pixel_data", probe_col[t][p], pixel_data);
            end
        end
        $display("Window %0d level %0d mode %0d: %s", t, exp_level[t], probe_mode[t],
                 (errors == err_start) ? "pass" : "fail");
    endtask

    initial begin
        rst_n       = 1'b0;
        adc_miso    = 1'b0;
        mode        = display_pkg::mode_menu;
        pixel_index = '0;
        bit_idx     = -1;
        frame_word  = '0;
        errors      = 0;
        num_tests   = 0;
        seed        = 32'he2dad4bf;
        cycle_limit = 2000;
        read_tests();
        cycle_limit = num_tests * 8 * 40 + 2000;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        // Outputs still hold their reset values here
        if (led !== 16'h0) report_mismatch("led", 16'h0, led);
        if (pixel_data !== 16'h0) report_mismatch("pixel_data", 16'h0, pixel_data);
        if (adc_cs !== 1'b1) report_mismatch("adc_cs", 16'h1, {15'h0, adc_cs});
        if (adc_sclk !== 1'b0) report_mismatch("adc_sclk", 16'h0, {15'h0, adc_sclk});
        if (seg_out.an !== 4'hF) report_mismatch("seg_out.an", 16'hF, {12'h0, seg_out.an});
        $display("Reset: %s", (errors == 0) ? "pass" : "fail");
        for (int t = 0; t < num_tests; t++) begin
            check_window(t);
        end
        $display("%0d windows run, %0d errors", num_tests, errors);
        if (errors == 0 && num_tests > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: audio_meter_tests.txt
# rnd s0 s1 s2 s3 s4 s5 s6 s7 level mode idx_a colour_a idx_b colour_b (all hex)
# rnd=1: sample columns are masks for random samples, level column ignored
0 100 350 9a0 420 080 700 010 233 9 1 a25 0000 a85 07e0
0 050 1ff 0a0 0f0 120 033 010 1c4 1 1 1620 0000 1680 07e0
0 400 fff 800 123 e00 777 abc 001 f 1 152 0000 1b2 07e0
0 c00 210 0ff b99 300 0c0 a10 050 c 0 005 ffff 7a8 0000
0 200 a55 3ff 1a0 0aa 9ff 4c4 123 a 0 17aa ffff 3c0 ffff
0 000 0ff 012 0a0 034 00f 0ff 001 0 2 005 0000 7a8 0000
0 111 222 333 444 555 666 7ff 100 7 3 41f 0000 c30 0000
1 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 0 0 41f ffff c30 0000
1 fff fff fff fff fff fff fff fff 0 0 000 ffff 7a8 0000
0 300 4ff 0f0 410 222 3a0 011 400 4 1 11b4 0000 1214 07e0

// File: flist.f
audio_pkg.sv
display_pkg.sv
mic_capture.sv
peak_detector.sv
level_display.sv
pixel_renderer.sv
audio_meter_top.sv
tb_clock_gen.sv
tb_audio_meter.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_audio_meter -f flist.f
out=$(./obj_dir/Vtb_audio_meter)
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
